// ==== source/mul_pkg.sv ====
package mul_pkg;

    // operand and product widths
    localparam int xlen = 32;
    localparam int prod_w = 2 * xlen;

    // tag field widths
    localparam int preg_w = 7;
    localparam int rs_w = 7;

    // register stages from operand capture to final product
    // capture, four compressor stages, final adder
    localparam int pipe_depth = 6;

    // queue must hold every operation the pipeline can have in flight
    localparam int result_depth = pipe_depth + 2;

    localparam int queue_ptr_w = $clog2(result_depth);

    // credit count reaches result_depth itself
    localparam int credit_w = $clog2(result_depth + 1);

    // travels beside the data from issue to result bus
    typedef struct packed {
        logic [preg_w-1:0] phys_addr;
        logic [rs_w-1:0]   rs_addr;
        logic [xlen-1:0]   pc;
    } mul_tag_t;

endpackage

// ==== source/mul_result_if.sv ====
`timescale 1ns/1ps

interface mul_result_if import mul_pkg::*; ();

    // one-cycle pulse per finished product
    logic              valid;
    logic [prod_w-1:0] product;
    mul_tag_t          tag;

    modport producer (
        output valid,
        output product,
        output tag
    );

    // no ready, credits guarantee a free slot
    modport consumer (
        input valid,
        input product,
        input tag
    );

endinterface

// ==== source/mul_operand_capture.sv ====
`timescale 1ns/1ps

module mul_operand_capture import mul_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_req,
    output logic                        issue_ack,
    input  logic [xlen-1:0]             issue_a,
    input  logic [xlen-1:0]             issue_b,
    input  mul_tag_t                    issue_tag,
    input  logic                        has_space,
    output logic                        accept,
    output logic [xlen-1:0][prod_w-1:0] rows,
    output logic                        valid,
    output mul_tag_t                    tag
);

    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    mul_tag_t        tag_q;

    // new request, previous handshake finished, queue has room
    assign accept = issue_req && !issue_ack && has_space;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_ack <= 1'b0;
            valid <= 1'b0;
        end else begin
            valid <= accept;
            if (accept) begin
                issue_ack <= 1'b1;
            end else if (!issue_req) begin
                issue_ack <= 1'b0;
            end
        end
    end

    // stage 0 operand registers
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= issue_a;
            b_q <= issue_b;
            tag_q <= issue_tag;
        end
    end

    assign tag = tag_q;

    // row i is A shifted by i where bit i of B is set
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            if (b_q[i]) begin
                rows[i] = {{(prod_w - xlen){1'b0}}, a_q} << i;
            end else begin
                rows[i] = '0;
            end
        end
    end

endmodule

// ==== source/mul_compress_stage.sv ====
`timescale 1ns/1ps

module mul_compress_stage import mul_pkg::*; #(
    parameter int n_in = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [n_in-1:0][prod_w-1:0]   in_rows,
    input  logic                          in_valid,
    input  mul_tag_t                      in_tag,
    output logic [n_in/2-1:0][prod_w-1:0] out_rows,
    output logic                          out_valid,
    output mul_tag_t                      out_tag
);

    logic [n_in/2-1:0][prod_w-1:0] next_rows;

    // each group of four rows becomes a sum row and a carry row
    for (genvar g = 0; g < n_in / 4; g++) begin : gen_group
        logic [prod_w-1:0] r0;
        logic [prod_w-1:0] r1;
        logic [prod_w-1:0] r2;
        logic [prod_w-1:0] r3;
        logic [prod_w-1:0] s1;
        logic [prod_w-1:0] c1;

        assign r0 = in_rows[4*g];
        assign r1 = in_rows[4*g+1];
        assign r2 = in_rows[4*g+2];
        assign r3 = in_rows[4*g+3];

        // first 3:2 level
        assign s1 = r0 ^ r1 ^ r2;
        assign c1 = ((r0 & r1) | (r1 & r2) | (r0 & r2)) << 1;

        // second level folds in the fourth row
        assign next_rows[2*g] = s1 ^ c1 ^ r3;
        assign next_rows[2*g+1] = ((s1 & c1) | (c1 & r3) | (s1 & r3)) << 1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_rows <= next_rows;
        out_tag <= in_tag;
    end

endmodule

// ==== source/mul_final_add.sv ====
`timescale 1ns/1ps

module mul_final_add import mul_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [1:0][prod_w-1:0]   in_rows,
    input  logic                     in_valid,
    input  mul_tag_t                 in_tag,
    mul_result_if.producer           res
);

    logic [prod_w-1:0] sum;

    // carry-propagate add of the last sum and carry rows
    assign sum = in_rows[0] + in_rows[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        res.product <= sum;
        res.tag <= in_tag;
    end

endmodule

// ==== source/mul_result_queue.sv ====
`timescale 1ns/1ps

module mul_result_queue import mul_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    mul_result_if.consumer    res,
    input  logic              accept,
    output logic              has_space,
    output logic              result_req,
    input  logic              result_ack,
    output logic [prod_w-1:0] result_product,
    output mul_tag_t          result_tag
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release
    } hs_state_t;

    logic [prod_w-1:0]      prod_mem [result_depth];
    mul_tag_t               tag_mem [result_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [credit_w-1:0]    held;
    logic [credit_w-1:0]    credits;
    hs_state_t              state;
    logic                   pop;

    // entry leaves once the consumer has dropped ack
    assign pop = (state == st_release) && !result_ack;
    assign result_req = (state == st_req);

    // held entries plus operations still in the pipeline
    assign has_space = credits < credit_w'(result_depth);

    always_ff @(posedge clk) begin
        if (res.valid) begin
            prod_mem[wr_ptr] <= res.product;
            tag_mem[wr_ptr] <= res.tag;
        end
    end

    // head entry, stable until pop
    assign result_product = prod_mem[rd_ptr];
    assign result_tag = tag_mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            held <= '0;
            credits <= '0;
        end else begin
            if (res.valid) begin
                if (wr_ptr == queue_ptr_w'(result_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == queue_ptr_w'(result_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            held <= held + credit_w'(res.valid) - credit_w'(pop);
            credits <= credits + credit_w'(accept) - credit_w'(pop);
        end
    end

    // four-phase output handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (held != '0 && !result_ack) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (result_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    if (!result_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== source/mul_unit_top.sv ====
`timescale 1ns/1ps

module mul_unit_top import mul_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_req,
    output logic              issue_ack,
    input  logic [xlen-1:0]   issue_a,
    input  logic [xlen-1:0]   issue_b,
    input  logic [preg_w-1:0] issue_phys_addr,
    input  logic [rs_w-1:0]   issue_rs_addr,
    input  logic [xlen-1:0]   issue_pc,
    output logic              result_req,
    input  logic              result_ack,
    output logic [prod_w-1:0] result_product,
    output logic [preg_w-1:0] result_phys_addr,
    output logic [rs_w-1:0]   result_rs_addr,
    output logic [xlen-1:0]   result_pc
);

    mul_tag_t issue_tag;
    mul_tag_t result_tag;
    logic     accept;
    logic     has_space;

    logic [xlen-1:0][prod_w-1:0]   rows_s0;
    logic [xlen/2-1:0][prod_w-1:0] rows_s1;
    logic [xlen/4-1:0][prod_w-1:0] rows_s2;
    logic [xlen/8-1:0][prod_w-1:0] rows_s3;
    logic [1:0][prod_w-1:0]        rows_s4;
    logic     valid_s0, valid_s1, valid_s2, valid_s3, valid_s4;
    mul_tag_t tag_s0, tag_s1, tag_s2, tag_s3, tag_s4;

    assign issue_tag = '{phys_addr: issue_phys_addr, rs_addr: issue_rs_addr, pc: issue_pc};

    assign result_phys_addr = result_tag.phys_addr;
    assign result_rs_addr = result_tag.rs_addr;
    assign result_pc = result_tag.pc;

    mul_result_if res_if ();

    mul_operand_capture capture_i (
        .clk       (clk),
        .rst       (rst),
        .issue_req (issue_req),
        .issue_ack (issue_ack),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .issue_tag (issue_tag),
        .has_space (has_space),
        .accept    (accept),
        .rows      (rows_s0),
        .valid     (valid_s0),
        .tag       (tag_s0)
    );

    // 32 -> 16 -> 8 -> 4 -> 2 rows
    mul_compress_stage #(.n_in(xlen)) compress_1_i (
        .clk(clk), .rst(rst),
        .in_rows(rows_s0), .in_valid(valid_s0), .in_tag(tag_s0),
        .out_rows(rows_s1), .out_valid(valid_s1), .out_tag(tag_s1)
    );

    mul_compress_stage #(.n_in(xlen/2)) compress_2_i (
        .clk(clk), .rst(rst),
        .in_rows(rows_s1), .in_valid(valid_s1), .in_tag(tag_s1),
        .out_rows(rows_s2), .out_valid(valid_s2), .out_tag(tag_s2)
    );

    mul_compress_stage #(.n_in(xlen/4)) compress_3_i (
        .clk(clk), .rst(rst),
        .in_rows(rows_s2), .in_valid(valid_s2), .in_tag(tag_s2),
        .out_rows(rows_s3), .out_valid(valid_s3), .out_tag(tag_s3)
    );

    mul_compress_stage #(.n_in(xlen/8)) compress_4_i (
        .clk(clk), .rst(rst),
        .in_rows(rows_s3), .in_valid(valid_s3), .in_tag(tag_s3),
        .out_rows(rows_s4), .out_valid(valid_s4), .out_tag(tag_s4)
    );

    mul_final_add final_add_i (
        .clk      (clk),
        .rst      (rst),
        .in_rows  (rows_s4),
        .in_valid (valid_s4),
        .in_tag   (tag_s4),
        .res      (res_if.producer)
    );

    mul_result_queue result_queue_i (
        .clk            (clk),
        .rst            (rst),
        .res            (res_if.consumer),
        .accept         (accept),
        .has_space      (has_space),
        .result_req     (result_req),
        .result_ack     (result_ack),
        .result_product (result_product),
        .result_tag     (result_tag)
    );

endmodule

// ==== testbench/mul_unit_tb.sv ====
`timescale 1ns/1ps

module mul_unit_tb import mul_pkg::*; ();

    localparam int n_corner = 10;
    localparam int n_stream = 80;
    localparam int n_slow = 100;
    localparam int max_ops = 200;
    localparam int cycles_per_op = 40;
    localparam int timeout_cycles = max_ops * cycles_per_op;

    logic              clk;
    logic              rst;
    logic              issue_req;
    logic              issue_ack;
    logic [xlen-1:0]   issue_a;
    logic [xlen-1:0]   issue_b;
    logic [preg_w-1:0] issue_phys_addr;
    logic [rs_w-1:0]   issue_rs_addr;
    logic [xlen-1:0]   issue_pc;
    logic              result_req;
    logic              result_ack;
    logic [prod_w-1:0] result_product;
    logic [preg_w-1:0] result_phys_addr;
    logic [rs_w-1:0]   result_rs_addr;
    logic [xlen-1:0]   result_pc;

    // issue side and result side each step their own LFSR
    logic [31:0] issue_lfsr;
    logic [31:0] ack_lfsr;

    logic [prod_w-1:0] exp_prod [$];
    mul_tag_t          exp_tag [$];

    int   errors = 0;
    int   issued = 0;
    int   received = 0;
    int   withheld = 0;
    int   cycle_count = 0;
    logic slow_ack;

    mul_unit_top mul_unit_i (
        .clk              (clk),
        .rst              (rst),
        .issue_req        (issue_req),
        .issue_ack        (issue_ack),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .issue_phys_addr  (issue_phys_addr),
        .issue_rs_addr    (issue_rs_addr),
        .issue_pc         (issue_pc),
        .result_req       (result_req),
        .result_ack       (result_ack),
        .result_product   (result_product),
        .result_phys_addr (result_phys_addr),
        .result_rs_addr   (result_rs_addr),
        .result_pc        (result_pc)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(inout logic [31:0] s, input int nbits, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            s = lfsr_next(s);
            v = {v[62:0], s[0]};
        end
    endtask

    function automatic logic [prod_w-1:0] ref_product(input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b);
        logic [prod_w-1:0] wide_a;
        logic [prod_w-1:0] wide_b;
        wide_a = {{(prod_w - xlen){1'b0}}, a};
        wide_b = {{(prod_w - xlen){1'b0}}, b};
        return wide_a * wide_b;
    endfunction

    task automatic random_tag(output mul_tag_t t);
        logic [63:0] bits;
        draw_bits(issue_lfsr, preg_w, bits);
        t.phys_addr = bits[preg_w-1:0];
        draw_bits(issue_lfsr, rs_w, bits);
        t.rs_addr = bits[rs_w-1:0];
        draw_bits(issue_lfsr, xlen, bits);
        t.pc = bits[xlen-1:0];
    endtask

    task automatic report_counts();
        $display("errors: %0d  issued: %0d  results: %0d  withheld acks: %0d",
                 errors, issued, received, withheld);
    endtask

    // full four-phase issue that starts and ends on a falling edge
    task automatic issue_op(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                            input mul_tag_t t, input int gap);
        int wait_cycles;
        wait_cycles = 0;
        issue_a = a;
        issue_b = b;
        issue_phys_addr = t.phys_addr;
        issue_rs_addr = t.rs_addr;
        issue_pc = t.pc;
        issue_req = 1'b1;
        @(negedge clk);
        while (!issue_ack) begin
            wait_cycles++;
            @(negedge clk);
        end
        // ack later than one edge means no credit was free
        if (wait_cycles > 0) begin
            withheld++;
        end
        exp_prod.push_back(ref_product(a, b));
        exp_tag.push_back(t);
        issued++;
        if (issued - received > result_depth) begin
            $display("more than %0d operations outstanding at %0t ns", result_depth, $time);
            errors++;
        end
        issue_req = 1'b0;
        @(negedge clk);
        while (issue_ack) begin
            @(negedge clk);
        end
        repeat (gap) @(negedge clk);
    endtask

    task automatic check_head();
        logic [prod_w-1:0] exp_p;
        mul_tag_t          exp_t;
        received++;
        if (exp_prod.size() == 0) begin
            $display("result_req raised at %0t ns with no operation outstanding", $time);
            errors++;
        end else begin
            exp_p = exp_prod.pop_front();
            exp_t = exp_tag.pop_front();
            if (result_product !== exp_p) begin
                $display("mismatch at %0t ns: product %h, expected %h",
                         $time, result_product, exp_p);
                errors++;
            end
            if (result_phys_addr !== exp_t.phys_addr) begin
                $display("mismatch at %0t ns: phys_addr %h, expected %h",
                         $time, result_phys_addr, exp_t.phys_addr);
                errors++;
            end
            if (result_rs_addr !== exp_t.rs_addr) begin
                $display("mismatch at %0t ns: rs_addr %h, expected %h",
                         $time, result_rs_addr, exp_t.rs_addr);
                errors++;
            end
            if (result_pc !== exp_t.pc) begin
                $display("mismatch at %0t ns: pc %h, expected %h", $time, result_pc, exp_t.pc);
                errors++;
            end
        end
    endtask

    task automatic check_stable(input logic [prod_w-1:0] prod, input mul_tag_t t);
        if (!result_req) begin
            $display("result_req dropped at %0t ns before result_ack was raised", $time);
            errors++;
        end
        if (result_product !== prod) begin
            $display("mismatch at %0t ns: result_product moved from %h to %h during request",
                     $time, prod, result_product);
            errors++;
        end
        if ({result_phys_addr, result_rs_addr, result_pc} !== t) begin
            $display("mismatch at %0t ns: result tag changed during request", $time);
            errors++;
        end
    endtask

    // result side answers each request and compares the head entry
    initial begin
        logic [63:0]       delay_bits;
        logic [prod_w-1:0] held_product;
        mul_tag_t          held_tag;
        int                ack_delay;

        result_ack = 1'b0;
        ack_lfsr = 32'd9287;
        forever begin
            @(negedge clk);
            if (!rst && result_req) begin
                check_head();
                held_product = result_product;
                held_tag.phys_addr = result_phys_addr;
                held_tag.rs_addr = result_rs_addr;
                held_tag.pc = result_pc;
                ack_delay = 0;
                if (slow_ack) begin
                    draw_bits(ack_lfsr, 4, delay_bits);
                    ack_delay = int'(delay_bits[3:0]);
                end
                for (int d = 0; d < ack_delay; d++) begin
                    @(negedge clk);
                    check_stable(held_product, held_tag);
                end
                result_ack = 1'b1;
                @(negedge clk);
                while (result_req) begin
                    @(negedge clk);
                end
                result_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [63:0]     rnd;
        logic [63:0]     gap_bits;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        mul_tag_t        t;

        rst = 1'b1;
        issue_req = 1'b0;
        issue_a = '0;
        issue_b = '0;
        issue_phys_addr = '0;
        issue_rs_addr = '0;
        issue_pc = '0;
        slow_ack = 1'b0;
        issue_lfsr = 32'd9287;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (4) begin
            @(negedge clk);
            if (issue_ack || result_req) begin
                $display("issue_ack or result_req high at %0t ns before any request", $time);
                errors++;
            end
        end

        // corner operands
        for (int c = 0; c < n_corner; c++) begin
            draw_bits(issue_lfsr, xlen, rnd);
            case (c)
                0: a = '0;
                2: a = 32'd1;
                4, 7, 9: a = '1;
                5: a = 32'h8000_0000;
                6: a = 32'd1 << rnd[4:0];
                8: a = 32'd1 << rnd[14:10];
                default: a = rnd[31:0];
            endcase
            case (c)
                1: b = '0;
                3, 9: b = 32'd1;
                4: b = '1;
                5: b = 32'h8000_0000;
                6: b = 32'd1 << rnd[9:5];
                7: b = 32'd1 << rnd[4:0];
                default: b = rnd[31:0];
            endcase
            random_tag(t);
            draw_bits(issue_lfsr, 3, gap_bits);
            issue_op(a, b, t, int'(gap_bits[2:0]));
        end

        // back to back stream with immediate ack
        for (int n = 0; n < n_stream; n++) begin
            draw_bits(issue_lfsr, xlen, rnd);
            a = rnd[31:0];
            draw_bits(issue_lfsr, xlen, rnd);
            b = rnd[31:0];
            random_tag(t);
            issue_op(a, b, t, 0);
        end

        // slow consumer drains the credits
        slow_ack = 1'b1;
        for (int n = 0; n < n_slow; n++) begin
            draw_bits(issue_lfsr, xlen, rnd);
            a = rnd[31:0];
            draw_bits(issue_lfsr, xlen, rnd);
            b = rnd[31:0];
            random_tag(t);
            draw_bits(issue_lfsr, 2, gap_bits);
            issue_op(a, b, t, int'(gap_bits[1:0]));
        end

        while (received < issued) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);

        if (exp_prod.size() != 0 || received != issued) begin
            $display("%0d results returned for %0d issued operations", received, issued);
            errors++;
        end
        if (withheld == 0) begin
            $display("issue_ack was never withheld while the result queue was full");
            errors++;
        end
        report_counts();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/mul_pkg.sv
source/mul_result_if.sv
source/mul_operand_capture.sv
source/mul_compress_stage.sv
source/mul_final_add.sv
source/mul_result_queue.sv
source/mul_unit_top.sv
testbench/mul_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module mul_unit_tb -f verilog.f \
    -o mul_unit_sim || exit 1
sim_out=$(./obj_dir/mul_unit_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
